//--- logic/corep.sv
//--------------------------------------------------------------------------
// core front-end package
// PC word address type, control-flow event kind and its codes
//--------------------------------------------------------------------------

package corep;

    //----------------------------------------------------------------------
    // addresses
    //----------------------------------------------------------------------

    // 40-bit byte PC with the two low bits dropped
    typedef logic [37:0] PC38_t;

    //----------------------------------------------------------------------
    // control-flow events
    //----------------------------------------------------------------------

    // kind of decoded event seen by fetch
    typedef logic [1:0] cf_kind_t;

    // no call or return, stack untouched
    localparam cf_kind_t CF_NONE = 2'd0;

    // push link address
    localparam cf_kind_t CF_CALL = 2'd1;

    // pop top of stack
    localparam cf_kind_t CF_RET = 2'd2;

    // return then call, top entry replaced
    localparam cf_kind_t CF_CALL_RET = 2'd3;

endpackage

//--- logic/distram_1rport_1wport.sv
//--------------------------------------------------------------------------
// distributed RAM array, one async read port and one clocked write port
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module distram_1rport_1wport #(
    parameter int INNER_WIDTH = 38,
    parameter int OUTER_WIDTH = 8,
    localparam int INDEX_W = $clog2(OUTER_WIDTH)
) (
    input  logic                   CLK,

    // read port
    input  logic [INDEX_W-1:0]     rindex,
    output logic [INNER_WIDTH-1:0] rdata,

    // write port
    input  logic                   wen,
    input  logic [INDEX_W-1:0]     windex,
    input  logic [INNER_WIDTH-1:0] wdata
);

    logic [INNER_WIDTH-1:0] mem [OUTER_WIDTH];

    // read is combinational
    assign rdata = mem[rindex];

    always_ff @(posedge CLK) begin
        if (wen) begin
            mem[windex] <= wdata;
        end
    end

endmodule

//--- logic/ras.sv
//--------------------------------------------------------------------------
// return address stack
// wrapping pointer, saturating count, restore from checkpoint snapshot
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module ras #(
    parameter int RAS_ENTRIES = 8,
    localparam int RAS_IDX_W = $clog2(RAS_ENTRIES),
    localparam int RAS_CNT_W = RAS_IDX_W + 1
) (
    input  logic                 CLK,
    input  logic                 nRST,

    // push request
    input  logic                 link_valid,
    input  corep::PC38_t         link_pc38,

    // pop request and current top
    input  logic                 ret_valid,
    output logic                 ret_fallback,
    output corep::PC38_t         ret_pc38,
    output logic [RAS_IDX_W-1:0] ret_ras_index,
    output logic [RAS_CNT_W-1:0] ret_ras_count,

    // restore from checkpoint
    input  logic                 update_valid,
    input  logic [RAS_IDX_W-1:0] update_ras_index,
    input  logic [RAS_CNT_W-1:0] update_ras_count
);

    import corep::*;

    localparam logic [RAS_CNT_W-1:0] COUNT_MAX = RAS_CNT_W'(RAS_ENTRIES);

    //----------------------------------------------------------------------
    // pointer and count
    //----------------------------------------------------------------------

    logic [RAS_IDX_W-1:0] sp;
    logic [RAS_IDX_W-1:0] next_sp;
    logic [RAS_IDX_W-1:0] sp_inc;
    logic [RAS_IDX_W-1:0] sp_dec;

    logic [RAS_CNT_W-1:0] count;
    logic [RAS_CNT_W-1:0] next_count;
    logic [RAS_CNT_W-1:0] count_inc;
    logic [RAS_CNT_W-1:0] count_dec;

    // array write side
    logic                 wr_en;
    logic [RAS_IDX_W-1:0] wr_index;
    PC38_t                top_pc38;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            sp    <= '0;
            count <= '0;
        end else begin
            sp    <= next_sp;
            count <= next_count;
        end
    end

    // index wraps, count stops at full depth
    assign sp_inc    = sp + 1'b1;
    assign sp_dec    = sp - 1'b1;
    assign count_inc = (count == COUNT_MAX) ? count : count + 1'b1;
    assign count_dec = count - 1'b1;

    // update first, then link with return, then link, then return
    always_comb begin
        next_sp    = sp;
        next_count = count;
        wr_en      = 1'b0;
        wr_index   = sp_inc;

        if (update_valid) begin
            next_sp    = update_ras_index;
            next_count = update_ras_count;
        end else if (link_valid && ret_valid) begin
            wr_en = 1'b1;
            if (ret_fallback) begin
                // empty stack, acts as a plain call
                next_sp    = sp_inc;
                next_count = count_inc;
            end else begin
                // replace top in place
                wr_index = sp;
            end
        end else if (link_valid) begin
            wr_en      = 1'b1;
            next_sp    = sp_inc;
            next_count = count_inc;
        end else if (ret_valid && !ret_fallback) begin
            next_sp    = sp_dec;
            next_count = count_dec;
        end
    end

    //----------------------------------------------------------------------
    // top of stack view
    //----------------------------------------------------------------------

    assign ret_fallback  = (count == '0);
    assign ret_pc38      = top_pc38;
    assign ret_ras_index = sp;
    assign ret_ras_count = count;

    distram_1rport_1wport #(
        .INNER_WIDTH($bits(PC38_t)),
        .OUTER_WIDTH(RAS_ENTRIES)
    ) ras_array_distram (
        .CLK   (CLK),
        .rindex(sp),
        .rdata (top_pc38),
        .wen   (wr_en),
        .windex(wr_index),
        .wdata (link_pc38)
    );

    // count can never run past the depth
    a_count_in_range: assert property (
        @(posedge CLK) disable iff (!nRST) count <= COUNT_MAX
    ) else $error("ras count %0d above depth", count);

    // fetch is stalled while a restore is in flight
    a_no_link_on_update: assert property (
        @(posedge CLK) disable iff (!nRST) !(update_valid && link_valid)
    ) else $error("ras link during update");

endmodule

//--- logic/ras_checkpoint_queue.sv
//--------------------------------------------------------------------------
// checkpoint FIFO of stack snapshots
// pops on resolve, restores the stack and flushes on a mispredict
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module ras_checkpoint_queue #(
    parameter int RAS_ENTRIES = 8,
    parameter int CKPT_DEPTH = 4,
    localparam int RAS_IDX_W = $clog2(RAS_ENTRIES),
    localparam int RAS_CNT_W = RAS_IDX_W + 1,
    localparam int PTR_W = $clog2(CKPT_DEPTH),
    localparam int OCC_W = PTR_W + 1
) (
    input  logic                 CLK,
    input  logic                 nRST,

    // snapshot before each event
    input  logic                 push_valid,
    input  logic [RAS_IDX_W-1:0] push_ras_index,
    input  logic [RAS_CNT_W-1:0] push_ras_count,
    output logic                 full,

    // in-order resolve from the back end
    input  logic                 resolve_valid,
    input  logic                 resolve_mispredict,

    // restore toward the stack
    output logic                 update_valid,
    output logic [RAS_IDX_W-1:0] update_ras_index,
    output logic [RAS_CNT_W-1:0] update_ras_count
);

    localparam logic [OCC_W-1:0] OCC_FULL = OCC_W'(CKPT_DEPTH);

    // snapshot storage
    logic [RAS_IDX_W-1:0] snap_index [CKPT_DEPTH];
    logic [RAS_CNT_W-1:0] snap_count [CKPT_DEPTH];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [OCC_W-1:0] occ;
    logic             empty;
    logic             do_push;
    logic             do_pop;

    assign full    = (occ == OCC_FULL);
    assign empty   = (occ == '0);
    assign do_push = push_valid && !full;
    assign do_pop  = resolve_valid && !empty;

    always_ff @(posedge CLK) begin
        if (do_push) begin
            snap_index[tail] <= push_ras_index;
            snap_count[tail] <= push_ras_count;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            head <= '0;
            tail <= '0;
            occ  <= '0;
        end else if (update_valid) begin
            // younger checkpoints are stale after a restore
            head <= '0;
            tail <= '0;
            occ  <= '0;
        end else begin
            if (do_push) begin
                tail <= tail + 1'b1;
            end
            if (do_pop) begin
                head <= head + 1'b1;
            end
            occ <= occ + OCC_W'(do_push) - OCC_W'(do_pop);
        end
    end

    // oldest snapshot always on the outputs
    assign update_valid     = do_pop && resolve_mispredict;
    assign update_ras_index = snap_index[head];
    assign update_ras_count = snap_count[head];

    a_no_push_when_full: assert property (
        @(posedge CLK) disable iff (!nRST) full |-> !push_valid
    ) else $error("checkpoint push while full");

    a_no_resolve_when_empty: assert property (
        @(posedge CLK) disable iff (!nRST) empty |-> !resolve_valid
    ) else $error("resolve with no checkpoint in flight");

endmodule

//--- logic/ret_predict_ctrl.sv
//--------------------------------------------------------------------------
// return prediction control
// fetch handshake, stack requests and next-PC select
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module ret_predict_ctrl #(
    parameter int RAS_ENTRIES = 8,
    localparam int RAS_IDX_W = $clog2(RAS_ENTRIES),
    localparam int RAS_CNT_W = RAS_IDX_W + 1
) (
    // fetch event stream
    input  logic                 fetch_valid,
    input  corep::cf_kind_t      fetch_kind,
    input  corep::PC38_t         fetch_pc38,
    input  corep::PC38_t         fetch_target_pc38,
    output logic                 fetch_ready,

    // prediction
    output logic                 pred_valid,
    output corep::PC38_t         pred_pc38,

    // stack side
    output logic                 link_valid,
    output corep::PC38_t         link_pc38,
    output logic                 ret_valid,
    input  logic                 ret_fallback,
    input  corep::PC38_t         ret_pc38,
    input  logic [RAS_IDX_W-1:0] ret_ras_index,
    input  logic [RAS_CNT_W-1:0] ret_ras_count,

    // checkpoint side
    output logic                 ckpt_push,
    output logic [RAS_IDX_W-1:0] ckpt_ras_index,
    output logic [RAS_CNT_W-1:0] ckpt_ras_count,
    input  logic                 ckpt_full,
    input  logic                 update_valid
);

    import corep::*;

    logic accept;
    logic is_link;
    logic is_ret;

    // restore owns the stack this cycle
    assign fetch_ready = !ckpt_full && !update_valid;
    assign accept      = fetch_valid && fetch_ready;

    assign is_link = (fetch_kind == CF_CALL) || (fetch_kind == CF_CALL_RET);
    assign is_ret  = (fetch_kind == CF_RET) || (fetch_kind == CF_CALL_RET);

    assign link_valid = accept && is_link;
    assign ret_valid  = accept && is_ret;
    assign link_pc38  = fetch_pc38 + PC38_t'(1);

    // top of stack only when there is one
    assign pred_valid = accept && (fetch_kind != CF_NONE);
    assign pred_pc38  = (is_ret && !ret_fallback) ? ret_pc38 : fetch_target_pc38;

    // snapshot is the state before this event
    assign ckpt_push      = pred_valid;
    assign ckpt_ras_index = ret_ras_index;
    assign ckpt_ras_count = ret_ras_count;

endmodule

//--- logic/ras_frontend_top.sv
//--------------------------------------------------------------------------
// return address prediction front end top level
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module ras_frontend_top #(
    parameter int RAS_ENTRIES = 8,
    parameter int CKPT_DEPTH = 4
) (
    input  logic            CLK,
    input  logic            nRST,

    // fetch events
    input  logic            fetch_valid,
    input  corep::cf_kind_t fetch_kind,
    input  corep::PC38_t    fetch_pc38,
    input  corep::PC38_t    fetch_target_pc38,
    output logic            fetch_ready,

    // prediction
    output logic            pred_valid,
    output corep::PC38_t    pred_pc38,

    // back-end resolve
    input  logic            resolve_valid,
    input  logic            resolve_mispredict
);

    import corep::*;

    localparam int RAS_IDX_W = $clog2(RAS_ENTRIES);
    localparam int RAS_CNT_W = RAS_IDX_W + 1;

    //----------------------------------------------------------------------
    // interconnect
    //----------------------------------------------------------------------

    logic                 link_valid;
    PC38_t                link_pc38;
    logic                 ret_valid;
    logic                 ret_fallback;
    PC38_t                ret_pc38;
    logic [RAS_IDX_W-1:0] ret_ras_index;
    logic [RAS_CNT_W-1:0] ret_ras_count;

    logic                 ckpt_push;
    logic [RAS_IDX_W-1:0] ckpt_ras_index;
    logic [RAS_CNT_W-1:0] ckpt_ras_count;
    logic                 ckpt_full;

    logic                 update_valid;
    logic [RAS_IDX_W-1:0] update_ras_index;
    logic [RAS_CNT_W-1:0] update_ras_count;

    ret_predict_ctrl #(
        .RAS_ENTRIES(RAS_ENTRIES)
    ) u_ret_predict_ctrl (
        .fetch_valid      (fetch_valid),
        .fetch_kind       (fetch_kind),
        .fetch_pc38       (fetch_pc38),
        .fetch_target_pc38(fetch_target_pc38),
        .fetch_ready      (fetch_ready),
        .pred_valid       (pred_valid),
        .pred_pc38        (pred_pc38),
        .link_valid       (link_valid),
        .link_pc38        (link_pc38),
        .ret_valid        (ret_valid),
        .ret_fallback     (ret_fallback),
        .ret_pc38         (ret_pc38),
        .ret_ras_index    (ret_ras_index),
        .ret_ras_count    (ret_ras_count),
        .ckpt_push        (ckpt_push),
        .ckpt_ras_index   (ckpt_ras_index),
        .ckpt_ras_count   (ckpt_ras_count),
        .ckpt_full        (ckpt_full),
        .update_valid     (update_valid)
    );

    ras #(
        .RAS_ENTRIES(RAS_ENTRIES)
    ) u_ras (
        .CLK             (CLK),
        .nRST            (nRST),
        .link_valid      (link_valid),
        .link_pc38       (link_pc38),
        .ret_valid       (ret_valid),
        .ret_fallback    (ret_fallback),
        .ret_pc38        (ret_pc38),
        .ret_ras_index   (ret_ras_index),
        .ret_ras_count   (ret_ras_count),
        .update_valid    (update_valid),
        .update_ras_index(update_ras_index),
        .update_ras_count(update_ras_count)
    );

    ras_checkpoint_queue #(
        .RAS_ENTRIES(RAS_ENTRIES),
        .CKPT_DEPTH (CKPT_DEPTH)
    ) u_ras_checkpoint_queue (
        .CLK               (CLK),
        .nRST              (nRST),
        .push_valid        (ckpt_push),
        .push_ras_index    (ckpt_ras_index),
        .push_ras_count    (ckpt_ras_count),
        .full              (ckpt_full),
        .resolve_valid     (resolve_valid),
        .resolve_mispredict(resolve_mispredict),
        .update_valid      (update_valid),
        .update_ras_index  (update_ras_index),
        .update_ras_count  (update_ras_count)
    );

endmodule

//--- tests/ras_frontend_tb.sv
//--------------------------------------------------------------------------
// testbench for the return address prediction front end
// directed and random fetch/resolve traffic checked against a stack model
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module ras_frontend_tb;

    import corep::*;

    localparam int RAS_ENTRIES    = 8;
    localparam int CKPT_DEPTH     = 4;
    localparam int PLANNED_EVENTS = 350;
    localparam int CYCLE_LIMIT    = PLANNED_EVENTS * 4;

    logic     CLK;
    logic     nRST;
    logic     fetch_valid;
    cf_kind_t fetch_kind;
    PC38_t    fetch_pc38;
    PC38_t    fetch_target_pc38;
    logic     fetch_ready;
    logic     pred_valid;
    PC38_t    pred_pc38;
    logic     resolve_valid;
    logic     resolve_mispredict;

    integer seed = 32'h01e5e27c;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    logic   auto_resolve = 1'b1;

    // reference stack and checkpoint queue
    PC38_t  ref_mem [RAS_ENTRIES];
    int     ref_sp = 0;
    int     ref_count = 0;
    int     snap_idx_q [$];
    int     snap_cnt_q [$];

    ras_frontend_top #(
        .RAS_ENTRIES(RAS_ENTRIES),
        .CKPT_DEPTH (CKPT_DEPTH)
    ) u_dut (
        .CLK               (CLK),
        .nRST              (nRST),
        .fetch_valid       (fetch_valid),
        .fetch_kind        (fetch_kind),
        .fetch_pc38        (fetch_pc38),
        .fetch_target_pc38 (fetch_target_pc38),
        .fetch_ready       (fetch_ready),
        .pred_valid        (pred_valid),
        .pred_pc38         (pred_pc38),
        .resolve_valid     (resolve_valid),
        .resolve_mispredict(resolve_mispredict)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    //----------------------------------------------------------------------
    // reference model
    //----------------------------------------------------------------------

    // top of stack for returns with something on it, else the BTB target
    function automatic PC38_t expected_pred(input cf_kind_t kind, input PC38_t tgt);
        if ((kind == CF_RET || kind == CF_CALL_RET) && ref_count != 0) begin
            return ref_mem[ref_sp];
        end
        return tgt;
    endfunction

    task automatic model_push(input PC38_t link);
        ref_sp = (ref_sp + 1) % RAS_ENTRIES;
        ref_mem[ref_sp] = link;
        if (ref_count < RAS_ENTRIES) begin
            ref_count++;
        end
    endtask

    task automatic apply_event(input cf_kind_t kind, input PC38_t pc);
        PC38_t link;
        link = pc + 38'd1;
        case (kind)
            CF_CALL: model_push(link);
            CF_RET: begin
                if (ref_count > 0) begin
                    ref_sp = (ref_sp + RAS_ENTRIES - 1) % RAS_ENTRIES;
                    ref_count--;
                end
            end
            CF_CALL_RET: begin
                if (ref_count > 0) begin
                    ref_mem[ref_sp] = link;
                end else begin
                    model_push(link);
                end
            end
            default: ;
        endcase
    endtask

    // compare at the falling edge, then step the model past the next rising edge
    task automatic check_and_step();
        logic  upd;
        logic  exp_ready;
        logic  exp_pv;
        PC38_t exp_pc;
        upd = resolve_valid && resolve_mispredict && (snap_idx_q.size() > 0);
        exp_ready = (snap_idx_q.size() != CKPT_DEPTH) && !upd;
        exp_pv = fetch_valid && exp_ready && (fetch_kind != CF_NONE);
        exp_pc = expected_pred(fetch_kind, fetch_target_pc38);
        checks += 2;
        assert (fetch_ready === exp_ready) else begin
            errors++;
            $display("ERR %0t fetch_ready expected %0b got %0b", $time, exp_ready, fetch_ready);
        end
        assert (pred_valid === exp_pv) else begin
            errors++;
            $display("ERR %0t pred_valid expected %0b got %0b", $time, exp_pv, pred_valid);
        end
        if (exp_pv) begin
            checks++;
            assert (pred_pc38 === exp_pc) else begin
                errors++;
                $display("ERR %0t pred_pc38 expected %h got %h", $time, exp_pc, pred_pc38);
            end
        end
        if (upd) begin
            ref_sp = snap_idx_q[0];
            ref_count = snap_cnt_q[0];
            snap_idx_q.delete();
            snap_cnt_q.delete();
        end else begin
            if (resolve_valid && snap_idx_q.size() > 0) begin
                void'(snap_idx_q.pop_front());
                void'(snap_cnt_q.pop_front());
            end
            if (exp_pv) begin
                snap_idx_q.push_back(ref_sp);
                snap_cnt_q.push_back(ref_count);
                apply_event(fetch_kind, fetch_pc38);
            end
        end
    endtask

    initial begin
        forever begin
            @(negedge CLK);
            if (nRST) begin
                check_and_step();
            end
        end
    end

    //----------------------------------------------------------------------
    // stimulus helpers
    //----------------------------------------------------------------------

    // one cycle of inputs, entered and left just after a rising edge
    task automatic drive_cycle(
        input  logic     fv,
        input  cf_kind_t kind,
        input  PC38_t    pc,
        input  PC38_t    tgt,
        input  logic     rv,
        input  logic     rm,
        output logic     taken
    );
        fetch_valid        = fv;
        fetch_kind         = kind;
        fetch_pc38         = pc;
        fetch_target_pc38  = tgt;
        resolve_valid      = rv;
        resolve_mispredict = rm;
        @(negedge CLK);
        taken = fv && fetch_ready;
        @(posedge CLK);
        #1;
    endtask

    task automatic send_event(input cf_kind_t kind, input PC38_t pc, input PC38_t tgt);
        logic taken;
        logic rv;
        taken = 1'b0;
        while (!taken) begin
            rv = auto_resolve && (snap_idx_q.size() > 0);
            drive_cycle(1'b1, kind, pc, tgt, rv, 1'b0, taken);
        end
    endtask

    task automatic drain_queue();
        logic taken;
        while (snap_idx_q.size() > 0) begin
            drive_cycle(1'b0, CF_NONE, '0, '0, 1'b1, 1'b0, taken);
        end
        drive_cycle(1'b0, CF_NONE, '0, '0, 1'b0, 1'b0, taken);
    endtask

    task automatic random_run(input int n);
        logic [63:0] raw;
        cf_kind_t    kind;
        PC38_t       pc;
        PC38_t       tgt;
        logic        taken;
        logic        rv;
        logic        rm;
        for (int i = 0; i < n; i++) begin
            kind = cf_kind_t'($random(seed));
            raw = {$random(seed), $random(seed)};
            pc = raw[37:0];
            raw = {$random(seed), $random(seed)};
            tgt = raw[37:0];
            // occasional bubble on the fetch side
            if (($random(seed) & 3) == 0) begin
                rv = (snap_idx_q.size() > 0) && (($random(seed) & 1) == 1);
                drive_cycle(1'b0, CF_NONE, '0, '0, rv, 1'b0, taken);
            end
            taken = 1'b0;
            while (!taken) begin
                rv = (snap_idx_q.size() > 0) && (($random(seed) & 1) == 1);
                rm = rv && (($random(seed) & 7) == 0);
                drive_cycle(1'b1, kind, pc, tgt, rv, rm, taken);
            end
        end
    endtask

    //----------------------------------------------------------------------
    // test sequence
    //----------------------------------------------------------------------

    initial begin
        logic taken;
        nRST               = 1'b0;
        fetch_valid        = 1'b0;
        fetch_kind         = CF_NONE;
        fetch_pc38         = '0;
        fetch_target_pc38  = '0;
        resolve_valid      = 1'b0;
        resolve_mispredict = 1'b0;
        repeat (3) @(posedge CLK);
        #1;
        nRST = 1'b1;

        // nested calls, returns unwind in reverse
        for (int i = 1; i <= 3; i++) send_event(CF_CALL, PC38_t'(i * 38'h100), 38'h3f00);
        for (int i = 0; i < 3; i++) send_event(CF_RET, PC38_t'(38'h7000 + i), 38'h3f00);

        // empty return, then overflow the stack
        send_event(CF_RET, 38'h7100, 38'h2222);
        for (int i = 0; i < 10; i++) send_event(CF_CALL, PC38_t'(38'h1000 + i * 16), 38'h44);
        for (int i = 0; i < 10; i++) send_event(CF_RET, PC38_t'(38'h7200 + i), 38'h55);

        // call-return swaps the top entry
        send_event(CF_CALL, 38'h2000, 38'h66);
        send_event(CF_CALL, 38'h2100, 38'h66);
        send_event(CF_CALL_RET, 38'h2200, 38'h77);
        send_event(CF_RET, 38'h7300, 38'h88);
        send_event(CF_RET, 38'h7310, 38'h88);

        // two live entries below the calls that get squashed
        for (int i = 0; i < 2; i++) send_event(CF_CALL, PC38_t'(38'h300 + i * 16), 38'h99);

        // mispredict on the oldest of three calls
        drain_queue();
        auto_resolve = 1'b0;
        for (int i = 0; i < 3; i++) send_event(CF_CALL, PC38_t'(38'h400 + i * 16), 38'h99);
        drive_cycle(1'b1, CF_CALL, 38'h500, 38'h99, 1'b1, 1'b1, taken);
        assert (!taken) else begin
            errors++;
            $display("fetch event was accepted during a stack restore");
        end
        auto_resolve = 1'b1;
        send_event(CF_CALL, 38'h500, 38'h99);
        for (int i = 0; i < 3; i++) send_event(CF_RET, PC38_t'(38'h7400 + i), 38'haa);

        // fill the checkpoint queue, hold an event until a resolve frees space
        drain_queue();
        auto_resolve = 1'b0;
        for (int i = 0; i < CKPT_DEPTH; i++) send_event(CF_CALL, PC38_t'(38'h600 + i), 38'hbb);
        for (int i = 0; i < 2; i++) begin
            drive_cycle(1'b1, CF_RET, 38'h7500, 38'hcc, 1'b0, 1'b0, taken);
            assert (!taken) else begin
                errors++;
                $display("fetch event was accepted with the checkpoint queue full");
            end
        end
        drive_cycle(1'b1, CF_RET, 38'h7500, 38'hcc, 1'b1, 1'b0, taken);
        send_event(CF_RET, 38'h7500, 38'hcc);
        auto_resolve = 1'b1;
        drain_queue();

        random_run(300);
        drain_queue();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // watchdog
    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d errors so far", cycles, errors);
        $display("Test failures found");
        $finish;
    end

endmodule

//--- vlog.f
logic/corep.sv
logic/distram_1rport_1wport.sv
logic/ras.sv
logic/ras_checkpoint_queue.sv
logic/ret_predict_ctrl.sv
logic/ras_frontend_top.sv
tests/ras_frontend_tb.sv
